// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_bridge
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model (
  input  logic                     clk,
  input  logic                     reset,
  input  mem_bridge_pkg::axi_ar_t  ar,
  input  logic                     arvalid,
  output logic                     arready,
  output mem_bridge_pkg::axi_r_t   r,
  output logic                     rvalid,
  input  logic                     rready,
  input  mem_bridge_pkg::axi_aw_t  aw,
  input  logic                     awvalid,
  output logic                     awready,
  input  mem_bridge_pkg::axi_w_t   w,
  input  logic                     wvalid,
  output logic                     wready,
  output mem_bridge_pkg::axi_b_t   b,
  output logic                     bvalid,
  input  logic                     bready
);

  logic [31:0] mem [logic [29:0]];
  mem_bridge_pkg::axi_ar_t rd_q [$];
  mem_bridge_pkg::axi_ar_t rd;
  mem_bridge_pkg::axi_aw_t aw_q;
  mem_bridge_pkg::axi_w_t  w_q;
  logic        aw_held;
  logic        w_held;
  logic [31:0] rng;
  logic [31:0] word;
  int          idx;
  int          i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // words never written read back as their word address xor a marker
  function automatic logic [31:0] read_word(input logic [29:0] wa);
    if (mem.exists(wa)) begin
      return mem[wa];
    end
    return {2'b00, wa} ^ 32'h5a5a0000;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      rng = 32'hb927;
      rd_q.delete();
      aw_held = 1'b0;
      w_held  = 1'b0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      rng = xorshift32(rng);
      arready <= rng[0];
      awready <= rng[1];
      wready  <= rng[2];
      if (arvalid && arready) begin
        rd_q.push_back(ar);
      end
      if (awvalid && awready) begin
        aw_q    = aw;
        aw_held = 1'b1;
      end
      if (wvalid && wready) begin
        w_q    = w;
        w_held = 1'b1;
      end
      // two queued reads may come back in either order
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end else if (!rvalid && rd_q.size() != 0 && rng[4:3] != 2'b00) begin
        idx = (rd_q.size() > 1 && rng[5]) ? 1 : 0;
        rd  = rd_q[idx];
        rd_q.delete(idx);
        r.id   <= rd.id;
        r.data <= read_word(rd.addr[31:2]);
        r.last <= 1'b1;
        rvalid <= 1'b1;
      end
      // write lands once both address and data are in
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end else if (!bvalid && aw_held && w_held && rng[7:6] != 2'b00) begin
        word = read_word(aw_q.addr[31:2]);
        for (i = 0; i < 4; i++) begin
          if (w_q.strb[i]) begin
            word[8*i +: 8] = w_q.data[8*i +: 8];
          end
        end
        mem[aw_q.addr[31:2]] = word;
        aw_held = 1'b0;
        w_held  = 1'b0;
        b.id   <= aw_q.id;
        bvalid <= 1'b1;
      end
    end
  end

endmodule

// ==== dv/tb_mem_bridge.sv ====
`timescale 1ns/1ns

module tb_mem_bridge;

  localparam int reset_cycles = 16;
  localparam int n_random     = 32;
  // fixed tests, then at most a fetch and a data access per random step
  localparam int n_trans      = 10 + 2 * n_random;

  logic        clk;
  logic        reset;
  logic        fetch_req;
  logic [31:0] fetch_addr;
  logic        fetch_addr_ok;
  logic        fetch_data_ok;
  logic [31:0] fetch_rdata;
  logic        data_req;
  logic        data_wr;
  logic [1:0]  data_size;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_addr_ok;
  logic        data_data_ok;
  logic [31:0] data_rdata;
  mem_bridge_pkg::axi_ar_t ar;
  mem_bridge_pkg::axi_r_t  r;
  mem_bridge_pkg::axi_aw_t aw;
  mem_bridge_pkg::axi_w_t  w;
  mem_bridge_pkg::axi_b_t  b;
  logic arvalid;
  logic arready;
  logic rvalid;
  logic rready;
  logic awvalid;
  logic awready;
  logic wvalid;
  logic wready;
  logic bvalid;
  logic bready;

  string       test_name = "reset";
  logic [31:0] exp_fetch_pa = '0;
  logic [31:0] exp_fetch = '0;
  logic [31:0] exp_data_pa = '0;
  logic [31:0] exp_data = '0;
  logic [31:0] exp_wdata = '0;
  logic [3:0]  exp_strb = '0;
  logic [1:0]  exp_size = '0;
  logic        exp_is_store = 1'b0;
  logic        req_seen = 1'b0;
  logic        both_pending = 1'b0;
  logic        fetch_out = 1'b0;
  logic        data_out = 1'b0;
  int          cycles = 0;
  logic [31:0] ref_mem [logic [29:0]];
  logic        fetch_r_hs;
  logic        data_done_hs;

  mem_bridge_top DUT (.*);

  axi_mem_model u_axi_mem_model (.*);

  assign fetch_r_hs   = rvalid && rready && r.id == mem_bridge_pkg::id_fetch;
  assign data_done_hs = (rvalid && rready && r.id == mem_bridge_pkg::id_data) ||
                        (bvalid && bready && b.id == mem_bridge_pkg::id_data);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // kseg0/kseg1 clear the top three bits
  function automatic logic [31:0] phys_addr(input logic [31:0] va);
    if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
      return {3'b000, va[28:0]};
    end
    return va;
  endfunction

  function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [31:0] va);
    if (size == 2'd0) begin
      return 4'b0001 << va[1:0];
    end else if (size == 2'd1) begin
      return va[1] ? 4'b1100 : 4'b0011;
    end
    return 4'b1111;
  endfunction

  function automatic logic [31:0] read_ref(input logic [31:0] pa);
    if (ref_mem.exists(pa[31:2])) begin
      return ref_mem[pa[31:2]];
    end
    return {2'b00, pa[31:2]} ^ 32'h5a5a0000;
  endfunction

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic value_error(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    stop_on_error($sformatf("[ERROR] %s: %s expected %08h, actual %08h",
                            test_name, what, expected, actual));
  endtask

  task automatic fetch_word(input logic [31:0] va);
    exp_fetch_pa = phys_addr(va);
    exp_fetch    = read_ref(exp_fetch_pa);
    @(posedge clk);
    fetch_req  <= 1'b1;
    fetch_addr <= va;
    req_seen   <= 1'b1;
    do @(posedge clk); while (!fetch_addr_ok);
    // keep requesting while busy so the port has to hold addr_ok low
    do @(posedge clk); while (!fetch_data_ok);
    fetch_req <= 1'b0;
  endtask

  task automatic data_access(input logic wr, input logic [1:0] size,
                             input logic [31:0] va, input logic [31:0] wdata);
    logic [31:0] merged;
    int i;
    exp_data_pa  = phys_addr(va);
    exp_data     = read_ref(exp_data_pa);
    exp_strb     = lane_mask(size, va);
    exp_size     = size;
    exp_wdata    = wdata;
    exp_is_store = wr;
    if (wr) begin
      merged = exp_data;
      for (i = 0; i < 4; i++) begin
        if (exp_strb[i]) begin
          merged[8*i +: 8] = wdata[8*i +: 8];
        end
      end
      ref_mem[exp_data_pa[31:2]] = merged;
    end
    @(posedge clk);
    data_req   <= 1'b1;
    data_wr    <= wr;
    data_size  <= size;
    data_addr  <= va;
    data_wdata <= wdata;
    req_seen   <= 1'b1;
    do @(posedge clk); while (!data_addr_ok);
    do @(posedge clk); while (!data_data_ok);
    data_req <= 1'b0;
  endtask

  // bookkeeping for ordering and outstanding checks
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (fetch_addr_ok && data_addr_ok && !data_wr) begin
      both_pending <= 1'b1;
    end else if (arvalid && arready) begin
      both_pending <= 1'b0;
    end
    if (fetch_addr_ok) begin
      fetch_out <= 1'b1;
    end else if (fetch_data_ok) begin
      fetch_out <= 1'b0;
    end
    if (data_addr_ok) begin
      data_out <= 1'b1;
    end else if (data_data_ok) begin
      data_out <= 1'b0;
    end
  end

  assert property (@(posedge clk) cycles > 0 && !req_seen |-> !(arvalid || awvalid ||
    wvalid || rready || bready || fetch_data_ok || data_data_ok || fetch_addr_ok ||
    data_addr_ok))
    else stop_on_error("bridge output went high before the first request");

  assert property (@(posedge clk) disable iff (reset)
    arvalid && ar.id == mem_bridge_pkg::id_fetch |-> ar.addr == exp_fetch_pa)
    else value_error("fetch araddr", $sampled(exp_fetch_pa), $sampled(ar.addr));

  assert property (@(posedge clk) disable iff (reset)
    arvalid && ar.id == mem_bridge_pkg::id_fetch |-> ar.size == 2'd2)
    else value_error("fetch arsize", 32'd2, {30'd0, $sampled(ar.size)});

  assert property (@(posedge clk) disable iff (reset)
    arvalid && ar.id == mem_bridge_pkg::id_data |-> ar.addr == exp_data_pa)
    else value_error("load araddr", $sampled(exp_data_pa), $sampled(ar.addr));

  assert property (@(posedge clk) disable iff (reset)
    arvalid && ar.id == mem_bridge_pkg::id_data |-> ar.size == exp_size)
    else value_error("load arsize", {30'd0, $sampled(exp_size)}, {30'd0, $sampled(ar.size)});

  assert property (@(posedge clk) disable iff (reset)
    fetch_data_ok |-> fetch_rdata == exp_fetch)
    else value_error("fetch rdata", $sampled(exp_fetch), $sampled(fetch_rdata));

  assert property (@(posedge clk) disable iff (reset)
    data_data_ok && !exp_is_store |-> data_rdata == exp_data)
    else value_error("load rdata", $sampled(exp_data), $sampled(data_rdata));

  assert property (@(posedge clk) disable iff (reset)
    awvalid |-> aw.addr == exp_data_pa)
    else value_error("awaddr", $sampled(exp_data_pa), $sampled(aw.addr));

  assert property (@(posedge clk) disable iff (reset)
    awvalid |-> aw.size == exp_size)
    else value_error("awsize", {30'd0, $sampled(exp_size)}, {30'd0, $sampled(aw.size)});

  assert property (@(posedge clk) disable iff (reset)
    awvalid |-> aw.id == mem_bridge_pkg::id_data)
    else value_error("awid", {28'd0, mem_bridge_pkg::id_data}, {28'd0, $sampled(aw.id)});

  assert property (@(posedge clk) disable iff (reset)
    wvalid |-> w.strb == exp_strb)
    else value_error("wstrb", {28'd0, $sampled(exp_strb)}, {28'd0, $sampled(w.strb)});

  assert property (@(posedge clk) disable iff (reset)
    wvalid |-> w.data == exp_wdata)
    else value_error("wdata", $sampled(exp_wdata), $sampled(w.data));

  assert property (@(posedge clk) disable iff (reset)
    wvalid |-> w.last)
    else stop_on_error("W beat went out without last set");

  assert property (@(posedge clk) disable iff (reset)
    both_pending && arvalid && arready |-> ar.id == mem_bridge_pkg::id_data)
    else stop_on_error("fetch read was issued ahead of a waiting data read");

  assert property (@(posedge clk) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(ar))
    else stop_on_error("AR channel changed before its handshake");

  assert property (@(posedge clk) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(aw))
    else stop_on_error("AW channel changed before its handshake");

  assert property (@(posedge clk) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(w))
    else stop_on_error("W channel changed before its handshake");

  assert property (@(posedge clk) disable iff (reset)
    !(fetch_out && fetch_addr_ok) && !(data_out && data_addr_ok))
    else stop_on_error("addr_ok went high while a request was outstanding");

  assert property (@(posedge clk) disable iff (reset)
    fetch_data_ok == $past(fetch_r_hs))
    else stop_on_error("fetch data_ok was not one cycle after its R handshake");

  assert property (@(posedge clk) disable iff (reset)
    data_data_ok == $past(data_done_hs))
    else stop_on_error("data data_ok was not one cycle after its R or B handshake");

  initial begin
    repeat (reset_cycles + 200 * n_trans) @(posedge clk);
    stop_on_error("watchdog expired before all transactions finished");
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] dva;
    logic [31:0] fva;
    logic [1:0]  size;
    logic [1:0]  off;
    int k;
    rnd        = 32'hb927;
    reset      = 1'b1;
    fetch_req  = 1'b0;
    fetch_addr = '0;
    data_req   = 1'b0;
    data_wr    = 1'b0;
    data_size  = '0;
    data_addr  = '0;
    data_wdata = '0;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
    repeat (4) @(posedge clk);

    test_name = "fetch_map";
    fetch_word(32'h8000_1000);
    fetch_word(32'ha000_1004);
    fetch_word(32'h0000_2008);

    test_name = "stores";
    data_access(1'b1, 2'd0, 32'ha000_0041, 32'h0000_ab00);
    data_access(1'b1, 2'd1, 32'h8000_0042, 32'hcdef_0000);
    data_access(1'b1, 2'd2, 32'h8000_0048, 32'h1234_5678);
    data_access(1'b0, 2'd2, 32'h8000_0040, 32'h0);
    data_access(1'b0, 2'd2, 32'ha000_0048, 32'h0);

    test_name = "concurrent";
    fork
      fetch_word(32'h8000_1010);
      data_access(1'b0, 2'd2, 32'h8000_0040, 32'h0);
    join

    test_name = "backpressure";
    for (k = 0; k < n_random; k++) begin
      rnd  = xorshift32(rnd);
      size = (rnd[1:0] == 2'd3) ? 2'd2 : rnd[1:0];
      off  = (size == 2'd0) ? rnd[13:12] : (size == 2'd1) ? {rnd[13], 1'b0} : 2'b00;
      dva  = (rnd[14] ? 32'ha000_0000 : 32'h8000_0000) | {22'd0, rnd[9:2], off};
      fva  = (rnd[15] ? 32'ha000_1000 : 32'h8000_1000) | {25'd0, rnd[20:16], 2'b00};
      if (rnd[11]) begin
        fork
          fetch_word(fva);
          data_access(rnd[10], size, dva, xorshift32(rnd ^ 32'h0f0f_1234));
        join
      end else begin
        data_access(rnd[10], size, dva, xorshift32(rnd ^ 32'h0f0f_1234));
      end
    end

    test_name = "done";
    repeat (4) @(posedge clk);
    $display("No errors");
    $finish;
  end

endmodule

// ==== hw/axi_arbiter.sv ====
`timescale 1ns/1ns

module axi_arbiter (
  input  logic                       clk,
  input  logic                       reset,
  input  mem_bridge_pkg::mem_req_t   fetch_req,
  input  logic                       fetch_req_valid,
  output logic                       fetch_req_ready,
  output mem_bridge_pkg::mem_resp_t  fetch_resp,
  output logic                       fetch_resp_valid,
  input  mem_bridge_pkg::mem_req_t   data_req,
  input  logic                       data_req_valid,
  output logic                       data_req_ready,
  output mem_bridge_pkg::mem_resp_t  data_resp,
  output logic                       data_resp_valid,
  output mem_bridge_pkg::axi_ar_t    ar,
  output logic                       arvalid,
  input  logic                       arready,
  input  mem_bridge_pkg::axi_r_t     r,
  input  logic                       rvalid,
  output logic                       rready,
  output mem_bridge_pkg::axi_aw_t    aw,
  output logic                       awvalid,
  input  logic                       awready,
  output mem_bridge_pkg::axi_w_t     w,
  output logic                       wvalid,
  input  logic                       wready,
  input  mem_bridge_pkg::axi_b_t     b,
  input  logic                       bvalid,
  output logic                       bready
);

  // outstanding per id, plus the direction of the data access
  logic fetch_busy;
  logic data_busy;
  logic data_is_wr;

  logic data_rd_go;
  logic data_wr_go;
  logic fetch_go;
  logic r_hs;
  logic b_hs;

  // data reads win over fetches when both wait for the ar slot
  assign data_rd_go = data_req_valid && !data_req.wr && !data_busy && !arvalid;
  assign data_wr_go = data_req_valid && data_req.wr && !data_busy && !awvalid && !wvalid;
  assign fetch_go   = fetch_req_valid && !fetch_busy && !arvalid && !data_rd_go;

  assign fetch_req_ready = fetch_go;
  assign data_req_ready  = data_rd_go || data_wr_go;

  assign rready = fetch_busy || (data_busy && !data_is_wr);
  assign bready = data_busy && data_is_wr;
  assign r_hs   = rvalid && rready;
  assign b_hs   = bvalid && bready;

  // steer responses back by id
  assign fetch_resp_valid = r_hs && r.id == mem_bridge_pkg::id_fetch;
  assign data_resp_valid  = (r_hs && r.id == mem_bridge_pkg::id_data) ||
                            (b_hs && b.id == mem_bridge_pkg::id_data);
  assign fetch_resp.rdata = r.data;
  assign data_resp.rdata  = r.data;

  always_ff @(posedge clk) begin
    if (reset) begin
      fetch_busy <= 1'b0;
      data_busy  <= 1'b0;
      data_is_wr <= 1'b0;
      arvalid    <= 1'b0;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
    end else begin
      if (fetch_go) begin
        fetch_busy <= 1'b1;
      end else if (fetch_resp_valid) begin
        fetch_busy <= 1'b0;
      end
      if (data_rd_go || data_wr_go) begin
        data_busy  <= 1'b1;
        data_is_wr <= data_wr_go;
      end else if (data_resp_valid) begin
        data_busy <= 1'b0;
      end
      if (fetch_go || data_rd_go) begin
        arvalid <= 1'b1;
      end else if (arready) begin
        arvalid <= 1'b0;
      end
      // aw and w rise together and drop on their own handshakes
      if (data_wr_go) begin
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
      end else begin
        if (awready) begin
          awvalid <= 1'b0;
        end
        if (wready) begin
          wvalid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_rd_go) begin
      ar.id   <= mem_bridge_pkg::id_data;
      ar.addr <= data_req.addr;
      ar.size <= data_req.size;
    end else if (fetch_go) begin
      ar.id   <= mem_bridge_pkg::id_fetch;
      ar.addr <= fetch_req.addr;
      ar.size <= fetch_req.size;
    end
    if (data_wr_go) begin
      aw.id   <= mem_bridge_pkg::id_data;
      aw.addr <= data_req.addr;
      aw.size <= data_req.size;
      w.data  <= data_req.wdata;
      w.strb  <= data_req.strb;
      w.last  <= 1'b1;
    end
  end

  // single-beat reads only, and never for an idle id
  assert property (@(posedge clk) disable iff (reset)
    r_hs |-> r.last && ((r.id == mem_bridge_pkg::id_fetch && fetch_busy) ||
                        (r.id == mem_bridge_pkg::id_data && data_busy && !data_is_wr)));

  assert property (@(posedge clk) disable iff (reset)
    b_hs |-> b.id == mem_bridge_pkg::id_data && data_busy && data_is_wr);

endmodule

// ==== hw/fetch_port.sv ====
`timescale 1ns/1ns

module fetch_port (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cpu_req,
  input  logic [mem_bridge_pkg::addr_w-1:0]   cpu_addr,
  output logic                                cpu_addr_ok,
  output logic                                cpu_data_ok,
  output logic [mem_bridge_pkg::data_w-1:0]   cpu_rdata,
  output mem_bridge_pkg::mem_req_t            req,
  output logic                                req_valid,
  input  logic                                req_ready,
  input  mem_bridge_pkg::mem_resp_t           resp,
  input  logic                                resp_valid
);

  mem_bridge_pkg::cpu_vaddr_u va;
  logic wait_resp;
  logic idle;

  assign va = cpu_addr;

  // one fetch in flight, from acceptance through data_ok
  assign idle        = !req_valid && !wait_resp && !cpu_data_ok;
  assign cpu_addr_ok = cpu_req && idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid   <= 1'b0;
      wait_resp   <= 1'b0;
      cpu_data_ok <= 1'b0;
    end else begin
      cpu_data_ok <= wait_resp && resp_valid;
      if (cpu_addr_ok) begin
        req_valid <= 1'b1;
      end else if (req_ready) begin
        req_valid <= 1'b0;
      end
      if (req_valid && req_ready) begin
        wait_resp <= 1'b1;
      end else if (resp_valid) begin
        wait_resp <= 1'b0;
      end
    end
  end

  // request payload, captured at acceptance
  always_ff @(posedge clk) begin
    if (cpu_addr_ok) begin
      req.wr    <= 1'b0;
      req.addr  <= mem_bridge_pkg::map_segment(va);
      req.size  <= mem_bridge_pkg::size_word;
      req.wdata <= '0;
      req.strb  <= '0;
    end
    if (resp_valid) begin
      cpu_rdata <= resp.rdata;
    end
  end

  // instruction fetches are always whole words
  assert property (@(posedge clk) disable iff (reset)
    cpu_addr_ok |-> va.lane_v.byte_sel == 2'b00);

  assert property (@(posedge clk) disable iff (reset)
    req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

// ==== hw/load_store_port.sv ====
`timescale 1ns/1ns

module load_store_port (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                cpu_req,
  input  logic                                cpu_wr,
  input  logic [1:0]                          cpu_size,
  input  logic [mem_bridge_pkg::addr_w-1:0]   cpu_addr,
  input  logic [mem_bridge_pkg::data_w-1:0]   cpu_wdata,
  output logic                                cpu_addr_ok,
  output logic                                cpu_data_ok,
  output logic [mem_bridge_pkg::data_w-1:0]   cpu_rdata,
  output mem_bridge_pkg::mem_req_t            req,
  output logic                                req_valid,
  input  logic                                req_ready,
  input  mem_bridge_pkg::mem_resp_t           resp,
  input  logic                                resp_valid
);

  mem_bridge_pkg::cpu_vaddr_u va;
  logic [mem_bridge_pkg::strb_w-1:0] strb;
  logic wait_resp;
  logic idle;

  assign va = cpu_addr;

  // byte lanes touched by this access
  always_comb begin
    case (cpu_size)
      mem_bridge_pkg::size_byte: strb = 4'b0001 << va.lane_v.byte_sel;
      mem_bridge_pkg::size_half: strb = va.lane_v.byte_sel[1] ? 4'b1100 : 4'b0011;
      mem_bridge_pkg::size_word: strb = 4'b1111;
      default:                   strb = 4'b0000;
    endcase
  end

  assign idle        = !req_valid && !wait_resp && !cpu_data_ok;
  assign cpu_addr_ok = cpu_req && idle;

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid   <= 1'b0;
      wait_resp   <= 1'b0;
      cpu_data_ok <= 1'b0;
    end else begin
      // loads and stores both end on the response pulse
      cpu_data_ok <= wait_resp && resp_valid;
      if (cpu_addr_ok) begin
        req_valid <= 1'b1;
      end else if (req_ready) begin
        req_valid <= 1'b0;
      end
      if (req_valid && req_ready) begin
        wait_resp <= 1'b1;
      end else if (resp_valid) begin
        wait_resp <= 1'b0;
      end
    end
  end

  // store data is already on its lanes, so it passes as a full word
  always_ff @(posedge clk) begin
    if (cpu_addr_ok) begin
      req.wr    <= cpu_wr;
      req.addr  <= mem_bridge_pkg::map_segment(va);
      req.size  <= cpu_size;
      req.wdata <= cpu_wdata;
      req.strb  <= strb;
    end
    if (resp_valid) begin
      cpu_rdata <= resp.rdata;
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    cpu_addr_ok && cpu_size == mem_bridge_pkg::size_half |-> !va.lane_v.byte_sel[0]);

  assert property (@(posedge clk) disable iff (reset)
    cpu_addr_ok && cpu_size == mem_bridge_pkg::size_word |-> va.lane_v.byte_sel == 2'b00);

  assert property (@(posedge clk) disable iff (reset)
    cpu_addr_ok |-> cpu_size != 2'd3);

endmodule

// ==== hw/mem_bridge_pkg.sv ====
package mem_bridge_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = 4;

  // axi ids, one per requester
  localparam logic [3:0] id_fetch = 4'd0;
  localparam logic [3:0] id_data  = 4'd1;

  // mips fixed-mapped segments
  localparam logic [2:0] seg_kseg0 = 3'b100;
  localparam logic [2:0] seg_kseg1 = 3'b101;

  // sram-like size codes, same encoding as axsize
  localparam logic [1:0] size_byte = 2'd0;
  localparam logic [1:0] size_half = 2'd1;
  localparam logic [1:0] size_word = 2'd2;

  // one virtual address, seen as segment/offset or as word/byte lane
  typedef union packed {
    struct packed {
      logic [2:0]  seg;
      logic [28:0] offset;
    } seg_v;
    struct packed {
      logic [29:0] word;
      logic [1:0]  byte_sel;
    } lane_v;
  } cpu_vaddr_u;

  typedef struct packed {
    logic              wr;
    logic [addr_w-1:0] addr;
    logic [1:0]        size;
    logic [data_w-1:0] wdata;
    logic [strb_w-1:0] strb;
  } mem_req_t;

  typedef struct packed {
    logic [data_w-1:0] rdata;
  } mem_resp_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [addr_w-1:0] addr;
    logic [1:0]        size;
  } axi_ar_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [addr_w-1:0] addr;
    logic [1:0]        size;
  } axi_aw_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef struct packed {
    logic [3:0]        id;
    logic [data_w-1:0] data;
    logic              last;
  } axi_r_t;

  typedef struct packed {
    logic [3:0] id;
  } axi_b_t;

  // kseg0 and kseg1 lose the top three bits, everything else is untouched
  function automatic logic [addr_w-1:0] map_segment(cpu_vaddr_u va);
    if (va.seg_v.seg == seg_kseg0 || va.seg_v.seg == seg_kseg1) begin
      return {3'b000, va.seg_v.offset};
    end
    return va;
  endfunction

endpackage

// ==== hw/mem_bridge_top.sv ====
`timescale 1ns/1ns

module mem_bridge_top (
  input  logic                                clk,
  input  logic                                reset,
  // fetch side
  input  logic                                fetch_req,
  input  logic [mem_bridge_pkg::addr_w-1:0]   fetch_addr,
  output logic                                fetch_addr_ok,
  output logic                                fetch_data_ok,
  output logic [mem_bridge_pkg::data_w-1:0]   fetch_rdata,
  // load/store side
  input  logic                                data_req,
  input  logic                                data_wr,
  input  logic [1:0]                          data_size,
  input  logic [mem_bridge_pkg::addr_w-1:0]   data_addr,
  input  logic [mem_bridge_pkg::data_w-1:0]   data_wdata,
  output logic                                data_addr_ok,
  output logic                                data_data_ok,
  output logic [mem_bridge_pkg::data_w-1:0]   data_rdata,
  // axi master
  output mem_bridge_pkg::axi_ar_t             ar,
  output logic                                arvalid,
  input  logic                                arready,
  input  mem_bridge_pkg::axi_r_t              r,
  input  logic                                rvalid,
  output logic                                rready,
  output mem_bridge_pkg::axi_aw_t             aw,
  output logic                                awvalid,
  input  logic                                awready,
  output mem_bridge_pkg::axi_w_t              w,
  output logic                                wvalid,
  input  logic                                wready,
  input  mem_bridge_pkg::axi_b_t              b,
  input  logic                                bvalid,
  output logic                                bready
);

  mem_bridge_pkg::mem_req_t  fetch_mem_req;
  mem_bridge_pkg::mem_req_t  data_mem_req;
  mem_bridge_pkg::mem_resp_t fetch_mem_resp;
  mem_bridge_pkg::mem_resp_t data_mem_resp;
  logic fetch_mem_req_valid;
  logic fetch_mem_req_ready;
  logic fetch_mem_resp_valid;
  logic data_mem_req_valid;
  logic data_mem_req_ready;
  logic data_mem_resp_valid;

  fetch_port u_fetch_port (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (fetch_req),
    .cpu_addr    (fetch_addr),
    .cpu_addr_ok (fetch_addr_ok),
    .cpu_data_ok (fetch_data_ok),
    .cpu_rdata   (fetch_rdata),
    .req         (fetch_mem_req),
    .req_valid   (fetch_mem_req_valid),
    .req_ready   (fetch_mem_req_ready),
    .resp        (fetch_mem_resp),
    .resp_valid  (fetch_mem_resp_valid)
  );

  load_store_port u_load_store_port (
    .clk         (clk),
    .reset       (reset),
    .cpu_req     (data_req),
    .cpu_wr      (data_wr),
    .cpu_size    (data_size),
    .cpu_addr    (data_addr),
    .cpu_wdata   (data_wdata),
    .cpu_addr_ok (data_addr_ok),
    .cpu_data_ok (data_data_ok),
    .cpu_rdata   (data_rdata),
    .req         (data_mem_req),
    .req_valid   (data_mem_req_valid),
    .req_ready   (data_mem_req_ready),
    .resp        (data_mem_resp),
    .resp_valid  (data_mem_resp_valid)
  );

  // both ports share one axi master
  axi_arbiter u_axi_arbiter (
    .clk              (clk),
    .reset            (reset),
    .fetch_req        (fetch_mem_req),
    .fetch_req_valid  (fetch_mem_req_valid),
    .fetch_req_ready  (fetch_mem_req_ready),
    .fetch_resp       (fetch_mem_resp),
    .fetch_resp_valid (fetch_mem_resp_valid),
    .data_req         (data_mem_req),
    .data_req_valid   (data_mem_req_valid),
    .data_req_ready   (data_mem_req_ready),
    .data_resp        (data_mem_resp),
    .data_resp_valid  (data_mem_resp_valid),
    .ar               (ar),
    .arvalid          (arvalid),
    .arready          (arready),
    .r                (r),
    .rvalid           (rvalid),
    .rready           (rready),
    .aw               (aw),
    .awvalid          (awvalid),
    .awready          (awready),
    .w                (w),
    .wvalid           (wvalid),
    .wready           (wready),
    .b                (b),
    .bvalid           (bvalid),
    .bready           (bready)
  );

endmodule

// ==== list.f ====
hw/mem_bridge_pkg.sv
hw/fetch_port.sv
hw/load_store_port.sv
hw/axi_arbiter.sv
hw/mem_bridge_top.sv
dv/axi_mem_model.sv
dv/tb_mem_bridge.sv
